/* axil_ram_pkg.sv */
package axil_ram_pkg;

    // Response codes as encoded on the AXI response channels.
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_decerr = 2'b11
    } resp_e;

    // Width of the word index for a store of size bytes and data_width bits per word.
    function automatic int word_index_width(
        input int size,
        input int data_width
    );
        int words;
        words = size / (data_width / 8);
        if (words > 1) begin
            return $clog2(words);
        end
        return 1; // A single-word store still needs one index bit.
    endfunction

    // Number of byte offset bits inside one data word.
    function automatic int offset_width(
        input int data_width
    );
        return $clog2(data_width / 8);
    endfunction

endpackage

/* axil_ram_store.sv */
`timescale 1ns/1ns

module axil_ram_store
    import axil_ram_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int SIZE       = 4096,

    localparam int STRB_WIDTH  = DATA_WIDTH / 8,
    localparam int INDEX_WIDTH = word_index_width(SIZE, DATA_WIDTH)
) (
    input  logic                   seq,

    input  logic                   store_we,
    input  logic [INDEX_WIDTH-1:0] store_waddr,
    input  logic [DATA_WIDTH-1:0]  store_wdata,
    input  logic [STRB_WIDTH-1:0]  store_wstrb,

    input  logic                   store_re,
    input  logic [INDEX_WIDTH-1:0] store_raddr,
    output logic [DATA_WIDTH-1:0]  store_rdata
);

    localparam int DEPTH = SIZE / STRB_WIDTH;

    localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(DEPTH - 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    if ((SIZE % STRB_WIDTH) != 0) begin : g_size_check
        $error("SIZE must be a multiple of the word size");
    end

    // Byte-masked write port.
    always_ff @(posedge seq) begin
        if (store_we) begin
            for (int i = 0; i < STRB_WIDTH; i++) begin
                if (store_wstrb[i]) begin
                    mem[store_waddr][8*i +: 8] <= store_wdata[8*i +: 8];
                end
            end
        end
    end

    // Registered read, a same-cycle write to the word returns old data.
    always_ff @(posedge seq) begin
        if (store_re) begin
            store_rdata <= mem[store_raddr];
        end
    end

    a_waddr_range: assert property (
        @(posedge seq)
        store_we |-> store_waddr <= LAST_INDEX
    );

    a_raddr_range: assert property (
        @(posedge seq)
        store_re |-> store_raddr <= LAST_INDEX
    );

endmodule

/* axil_ram_write.sv */
`timescale 1ns/1ns

module axil_ram_write
    import axil_ram_pkg::*;
#(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32,
    parameter int SIZE       = 4096,

    localparam int STRB_WIDTH   = DATA_WIDTH / 8,
    localparam int INDEX_WIDTH  = word_index_width(SIZE, DATA_WIDTH),
    localparam int OFFSET_WIDTH = offset_width(DATA_WIDTH)
) (
    input  logic                   seq,
    input  logic                   reset,
    input  logic                   pause,

    input  logic                   awvalid,
    output logic                   awready,
    input  logic [ADDR_WIDTH-1:0]  awaddr,

    input  logic                   wvalid,
    output logic                   wready,
    input  logic [DATA_WIDTH-1:0]  wdata,
    input  logic [STRB_WIDTH-1:0]  wstrb,

    output logic                   bvalid,
    input  logic                   bready,
    output resp_e                  bresp,

    output logic                   store_we,
    output logic [INDEX_WIDTH-1:0] store_waddr,
    output logic [DATA_WIDTH-1:0]  store_wdata,
    output logic [STRB_WIDTH-1:0]  store_wstrb
);

    localparam logic [ADDR_WIDTH-1:0] SIZE_LIMIT = ADDR_WIDTH'(SIZE);

    logic                  aw_full;
    logic [ADDR_WIDTH-1:0] aw_addr;
    logic                  w_full;
    logic [DATA_WIDTH-1:0] w_data;
    logic [STRB_WIDTH-1:0] w_strb;

    logic fire;
    logic legal;

    assign awready = !aw_full && !pause;
    assign wready  = !w_full && !pause;

    // Fires once address and data are paired and the response slot is free.
    assign fire  = aw_full && w_full && !bvalid;
    assign legal = (aw_addr[OFFSET_WIDTH-1:0] == '0) && (aw_addr < SIZE_LIMIT);

    assign store_we    = fire && legal;
    assign store_waddr = aw_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign store_wdata = w_data;
    assign store_wstrb = w_strb;

    always_ff @(posedge seq) begin
        if (reset) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_full <= 1'b1;
            end else if (fire) begin
                aw_full <= 1'b0;
            end

            if (wvalid && wready) begin
                w_full <= 1'b1;
            end else if (fire) begin
                w_full <= 1'b0;
            end

            if (fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0; // Response taken by the master.
            end
        end
    end

    always_ff @(posedge seq) begin
        if (awvalid && awready) begin
            aw_addr <= awaddr;
        end
        if (wvalid && wready) begin
            w_data <= wdata;
            w_strb <= wstrb;
        end
        if (fire) begin
            bresp <= legal ? resp_okay : resp_decerr;
        end
    end

    // A stalled write response must hold until the master takes it.
    a_b_stable: assert property (
        @(posedge seq) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp)
    );

    // The store index maps back to the exact bus address of every write.
    a_we_range: assert property (
        @(posedge seq) disable iff (reset)
        store_we |-> (ADDR_WIDTH'(store_waddr) << OFFSET_WIDTH) == aw_addr
    );

endmodule

/* axil_ram_read.sv */
`timescale 1ns/1ns

module axil_ram_read
    import axil_ram_pkg::*;
#(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32,
    parameter int SIZE       = 4096,

    localparam int INDEX_WIDTH  = word_index_width(SIZE, DATA_WIDTH),
    localparam int OFFSET_WIDTH = offset_width(DATA_WIDTH)
) (
    input  logic                   seq,
    input  logic                   reset,
    input  logic                   pause,

    input  logic                   arvalid,
    output logic                   arready,
    input  logic [ADDR_WIDTH-1:0]  araddr,

    output logic                   rvalid,
    input  logic                   rready,
    output logic [DATA_WIDTH-1:0]  rdata,
    output resp_e                  rresp,

    output logic                   store_re,
    output logic [INDEX_WIDTH-1:0] store_raddr,
    input  logic [DATA_WIDTH-1:0]  store_rdata
);

    localparam logic [ADDR_WIDTH-1:0] SIZE_LIMIT = ADDR_WIDTH'(SIZE);

    logic                  ar_full;
    logic [ADDR_WIDTH-1:0] ar_addr;

    logic lookup_valid; // Store lookup in progress.
    logic lookup_err;

    logic issue;
    logic legal;

    assign arready = !ar_full && !pause;

    // The response slot is free by the time the lookup completes.
    assign issue = ar_full && !lookup_valid && (!rvalid || rready);
    assign legal = (ar_addr[OFFSET_WIDTH-1:0] == '0) && (ar_addr < SIZE_LIMIT);

    assign store_re    = issue && legal;
    assign store_raddr = ar_addr[OFFSET_WIDTH +: INDEX_WIDTH];

    always_ff @(posedge seq) begin
        if (reset) begin
            ar_full      <= 1'b0;
            lookup_valid <= 1'b0;
            rvalid       <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                ar_full <= 1'b1;
            end else if (issue) begin
                ar_full <= 1'b0;
            end

            lookup_valid <= issue;

            if (lookup_valid) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge seq) begin
        if (arvalid && arready) begin
            ar_addr <= araddr;
        end
        if (issue) begin
            lookup_err <= !legal;
        end
        if (lookup_valid) begin
            rdata <= lookup_err ? '0 : store_rdata; // Decode errors read as zero.
            rresp <= lookup_err ? resp_decerr : resp_okay;
        end
    end

    // A stalled read response must hold until the master takes it.
    a_r_stable: assert property (
        @(posedge seq) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    );

endmodule

/* axil_ram.sv */
`timescale 1ns/1ns

module axil_ram
    import axil_ram_pkg::*;
#(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32,
    parameter int SIZE       = 4096,

    localparam int STRB_WIDTH  = DATA_WIDTH / 8,
    localparam int INDEX_WIDTH = word_index_width(SIZE, DATA_WIDTH)
) (
    input  logic                  seq,
    input  logic                  reset,
    input  logic                  pause,

    input  logic                  awvalid,
    output logic                  awready,
    input  logic [ADDR_WIDTH-1:0] awaddr,

    input  logic                  wvalid,
    output logic                  wready,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic [STRB_WIDTH-1:0] wstrb,

    output logic                  bvalid,
    input  logic                  bready,
    output resp_e                 bresp,

    input  logic                  arvalid,
    output logic                  arready,
    input  logic [ADDR_WIDTH-1:0] araddr,

    output logic                  rvalid,
    input  logic                  rready,
    output logic [DATA_WIDTH-1:0] rdata,
    output resp_e                 rresp
);

    logic                   store_we;
    logic [INDEX_WIDTH-1:0] store_waddr;
    logic [DATA_WIDTH-1:0]  store_wdata;
    logic [STRB_WIDTH-1:0]  store_wstrb;
    logic                   store_re;
    logic [INDEX_WIDTH-1:0] store_raddr;
    logic [DATA_WIDTH-1:0]  store_rdata;

    axil_ram_write #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .SIZE       (SIZE)
    ) write0 (
        .seq         (seq),
        .reset       (reset),
        .pause       (pause),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .store_we    (store_we),
        .store_waddr (store_waddr),
        .store_wdata (store_wdata),
        .store_wstrb (store_wstrb)
    );

    axil_ram_read #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .SIZE       (SIZE)
    ) read0 (
        .seq         (seq),
        .reset       (reset),
        .pause       (pause),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp),
        .store_re    (store_re),
        .store_raddr (store_raddr),
        .store_rdata (store_rdata)
    );

    axil_ram_store #(
        .DATA_WIDTH (DATA_WIDTH),
        .SIZE       (SIZE)
    ) store0 (
        .seq         (seq),
        .store_we    (store_we),
        .store_waddr (store_waddr),
        .store_wdata (store_wdata),
        .store_wstrb (store_wstrb),
        .store_re    (store_re),
        .store_raddr (store_raddr),
        .store_rdata (store_rdata)
    );

endmodule

/* axil_ram_tb.sv */
`timescale 1ns/1ns

module axil_ram_tb;

    localparam int SIZE        = 4096;
    localparam int WORDS       = SIZE / 4;
    localparam int INDEX_BITS  = $clog2(WORDS);
    localparam int N_RANDOM    = 1000;
    localparam int TRANSACTIONS = 2 * WORDS + 32 + 15 + N_RANDOM + 5;
    localparam int TIMEOUT     = 8 * TRANSACTIONS + 200;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    localparam int READY_HIGH   = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_LOW    = 2;

    logic        seq     = 1'b0;
    logic        reset   = 1'b1;
    logic        pause   = 1'b0;
    logic        awvalid = 1'b0;
    logic [31:0] awaddr  = '0;
    logic        wvalid  = 1'b0;
    logic [31:0] wdata   = '0;
    logic [3:0]  wstrb   = '0;
    logic        bready  = 1'b0;
    logic        arvalid = 1'b0;
    logic [31:0] araddr  = '0;
    logic        rready  = 1'b0;
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;

    logic [31:0] shadow [WORDS];
    logic [1:0]  exp_write [$];
    logic [33:0] exp_read [$];

    int    cycle          = 0;
    int    errors         = 0;
    int    b_count        = 0;
    int    r_count        = 0;
    int    writes_issued  = 0;
    int    reads_issued   = 0;
    int    ready_mode     = READY_HIGH;
    bit    check_latency  = 1'b0;
    string test_name      = "reset";

    always #50 seq = ~seq;

    axil_ram #(
        .ADDR_WIDTH (32),
        .DATA_WIDTH (32),
        .SIZE       (SIZE)
    ) dut0 (
        .seq     (seq),
        .reset   (reset),
        .pause   (pause),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    // Expected {resp, data} of one access; a legal write also updates the shadow memory.
    function automatic logic [33:0] reference(input bit is_write, input logic [31:0] addr,
                                              input logic [31:0] data, input logic [3:0] strb);
        logic [31:0] word;
        if (addr[1:0] != 2'b00 || addr >= 32'(SIZE)) begin
            return {RESP_DECERR, 32'h0};
        end
        word = shadow[addr[INDEX_BITS+1:2]];
        if (!is_write) begin
            return {RESP_OKAY, word};
        end
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                word[8*i +: 8] = data[8*i +: 8]; // Only strobed bytes change.
            end
        end
        shadow[addr[INDEX_BITS+1:2]] = word;
        return {RESP_OKAY, 32'h0};
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int aw_delay, input int w_delay,
                            input bit wait_resp);
        logic [33:0] expected;
        int n;
        bit aw_done;
        bit w_done;
        expected = reference(1'b1, addr, data, strb);
        exp_write.push_back(expected[33:32]);
        n = 0;
        aw_done = 1'b0;
        w_done = 1'b0;
        awaddr <= addr;
        wdata <= data;
        wstrb <= strb;
        while (!(aw_done && w_done)) begin
            awvalid <= !aw_done && (n >= aw_delay);
            wvalid <= !w_done && (n >= w_delay);
            @(posedge seq);
            if (awvalid && awready) begin
                aw_done = 1'b1;
            end
            if (wvalid && wready) begin
                w_done = 1'b1;
            end
            n++;
        end
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        writes_issued++;
        while (wait_resp && b_count < writes_issued) begin
            @(posedge seq);
        end
    endtask

    task automatic do_read(input logic [31:0] addr, input int ar_delay, input bit wait_resp);
        int n;
        bit done;
        exp_read.push_back(reference(1'b0, addr, 32'h0, 4'h0));
        n = 0;
        done = 1'b0;
        araddr <= addr;
        while (!done) begin
            arvalid <= (n >= ar_delay);
            @(posedge seq);
            if (arvalid && arready) begin
                done = 1'b1;
            end
            n++;
        end
        arvalid <= 1'b0;
        reads_issued++;
        while (wait_resp && r_count < reads_issued) begin
            @(posedge seq);
        end
    endtask

    always @(posedge seq) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("Timed out after %0d cycles waiting for responses, %0d errors", cycle, errors);
            $display(">>> FAIL");
            $finish;
        end
    end

    always @(posedge seq) begin
        if (ready_mode == READY_RANDOM) begin
            bready <= ($urandom % 4) != 0;
            rready <= ($urandom % 4) != 0;
        end else begin
            bready <= (ready_mode == READY_HIGH);
            rready <= (ready_mode == READY_HIGH);
        end
    end

    // Response checker, all values sampled at the rising edge.
    always @(posedge seq) begin
        static bit          reset_prev = 1'b0;
        static bit          pause_prev = 1'b0;
        static bit          b_stalled  = 1'b0;
        static bit          r_stalled  = 1'b0;
        static logic [1:0]  held_bresp = '0;
        static logic [33:0] held_r     = '0;
        static int          wr_cycle   = 0;
        static int          ar_cycle   = 0;
        static int          paused_resp = 0;
        logic [1:0]  exp_b;
        logic [33:0] exp_r;
        if ((reset && cycle != 0) || reset_prev) begin
            check("reset bvalid", 32'd0, 32'(bvalid));
            check("reset rvalid", 32'd0, 32'(rvalid));
        end
        reset_prev = reset;
        if ((awvalid && awready) || (wvalid && wready)) begin
            wr_cycle = cycle; // Later of the two handshakes.
        end
        if (arvalid && arready) begin
            ar_cycle = cycle;
        end
        if (b_stalled) begin
            check({test_name, " stalled bvalid"}, 32'd1, 32'(bvalid));
            check({test_name, " stalled bresp"}, 32'(held_bresp), 32'(bresp));
        end
        if (r_stalled) begin
            check({test_name, " stalled rvalid"}, 32'd1, 32'(rvalid));
            check({test_name, " stalled rresp"}, 32'(held_r[33:32]), 32'(rresp));
            check({test_name, " stalled rdata"}, held_r[31:0], rdata);
        end
        if (bvalid && bready) begin
            if (exp_write.size() == 0) begin
                $display("Write response arrived with no write outstanding at cycle %0d", cycle);
                errors++;
            end else begin
                exp_b = exp_write.pop_front();
                check({test_name, " bresp"}, 32'(exp_b), 32'(bresp));
                if (check_latency) begin
                    check({test_name, " write latency"}, 32'd1, 32'(cycle - wr_cycle - 1));
                end
            end
            b_count <= b_count + 1;
        end
        if (rvalid && rready) begin
            if (exp_read.size() == 0) begin
                $display("Read response arrived with no read outstanding at cycle %0d", cycle);
                errors++;
            end else begin
                exp_r = exp_read.pop_front();
                check({test_name, " rresp"}, 32'(exp_r[33:32]), 32'(rresp));
                check({test_name, " rdata"}, exp_r[31:0], rdata);
                if (check_latency) begin
                    check({test_name, " read latency"}, 32'd2, 32'(cycle - ar_cycle - 1));
                end
            end
            r_count <= r_count + 1;
        end
        b_stalled = bvalid && !bready;
        r_stalled = rvalid && !rready;
        held_bresp = bresp;
        held_r = {rresp, rdata};
        if (pause && (awready || wready || arready)) begin
            $display("A ready output was high while pause was set at cycle %0d", cycle);
            errors++;
        end
        if (pause && ((bvalid && bready) || (rvalid && rready))) begin
            paused_resp++;
        end
        if (pause_prev && !pause && paused_resp == 0) begin
            $display("No waiting response completed while pause was set");
            errors++;
        end
        pause_prev = pause;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] bad_addr [5];
        void'($urandom(32'h448cec6a));
        bad_addr = '{32'h0000_0102, 32'h0000_0081, 32'(SIZE), 32'(SIZE + 4), 32'hFFFF_FFFC};
        repeat (4) @(posedge seq);
        reset <= 1'b0;
        @(posedge seq);

        test_name = "fill";
        check_latency = 1'b1;
        for (int i = 0; i < WORDS; i++) begin
            do_write(32'(4 * i), 32'(4 * i), 4'hF, 0, 0, 1'b1);
        end
        for (int i = 0; i < WORDS; i++) begin
            do_read(32'(4 * i), 0, 1'b1);
        end
        check_latency = 1'b0;

        test_name = "strobe";
        for (int i = 0; i < 16; i++) begin
            do_write(32'h200 + 32'(4 * i), $urandom, 4'(i), i % 3, (i + 1) % 3, 1'b1);
        end
        for (int i = 0; i < 16; i++) begin
            do_read(32'h200 + 32'(4 * i), 0, 1'b1);
        end

        test_name = "decode";
        for (int i = 0; i < 5; i++) begin
            do_write(bad_addr[i], 32'hDEAD_BEEF, 4'hF, 0, 1, 1'b1);
            do_read(bad_addr[i], 0, 1'b1);
        end
        do_read(32'h100, 0, 1'b1); // Neighbours and aliases of the bad addresses.
        do_read(32'h080, 0, 1'b1);
        do_read(32'h000, 0, 1'b1);
        do_read(32'h004, 0, 1'b1);
        do_read(32'hFFC, 0, 1'b1);

        test_name = "random";
        ready_mode = READY_RANDOM;
        for (int n = 0; n < N_RANDOM; n++) begin
            addr = 32'($urandom % 32'(SIZE + 64));
            data = $urandom;
            if ($urandom % 2 == 0) begin
                addr[1:0] = 2'b00;
            end
            if ($urandom % 2 == 0) begin
                do_write(addr, data, 4'($urandom), int'($urandom % 4), int'($urandom % 4), 1'b1);
            end else begin
                do_read(addr, int'($urandom % 4), 1'b1);
            end
        end

        test_name = "pause";
        ready_mode = READY_LOW;
        repeat (2) @(posedge seq);
        do_write(32'h040, 32'hA5A5_0001, 4'hF, 0, 0, 1'b0); // Responses left waiting.
        do_read(32'h044, 0, 1'b0);
        pause <= 1'b1;
        repeat (3) @(posedge seq);
        ready_mode = READY_HIGH;
        while (b_count < writes_issued || r_count < reads_issued) begin
            @(posedge seq);
        end
        fork
            do_write(32'h048, 32'h5A5A_0002, 4'hF, 0, 0, 1'b1);
            do_read(32'h04C, 0, 1'b1);
            begin
                repeat (8) @(posedge seq);
                pause <= 1'b0;
            end
        join
        do_read(32'h048, 0, 1'b1);

        repeat (5) @(posedge seq);
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
axil_ram_pkg.sv
axil_ram_store.sv
axil_ram_write.sv
axil_ram_read.sv
axil_ram.sv
axil_ram_tb.sv

/* Makefile */
SRCS = axil_ram_pkg.sv axil_ram_store.sv axil_ram_write.sv axil_ram_read.sv \
       axil_ram.sv axil_ram_tb.sv

.PHONY: all run clean

all: run

obj_dir/Vaxil_ram_tb: build.f $(SRCS)
	verilator --binary --timing --assert --top-module axil_ram_tb -f build.f

run: obj_dir/Vaxil_ram_tb
	./obj_dir/Vaxil_ram_tb > sim.log 2>&1; cat sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
